// File: mips_exec_unit.f
+incdir+design
design/mips_alu_pkg.sv
design/operand_stage.sv
design/mips_alu.sv
design/hilo_result_stage.sv
design/mips_exec_unit.sv
testbench/tb_mips_exec_unit.sv

// File: run_sim.sh
#!/bin/sh
# Build the testbench with Verilator, run it into sim.log and scan the log for failures.
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary -Wno-fatal --top-module tb_mips_exec_unit -f mips_exec_unit.f \
	> build.log 2>&1 || { echo "verilator build failed, see build.log"; exit 1; }

./obj_dir/Vtb_mips_exec_unit > sim.log 2>&1 || { echo "simulation did not run to the end"; exit 1; }

grep -q "CHECKS FAILED" sim.log && { echo "simulation reported failures, see sim.log"; exit 1; }
echo "simulation finished without failures"
exit 0

// File: testbench/exec_stim.txt
// func rs_val rt_val use_imm imm_signed imm exp_result exp_hi exp_flags
// flags are {zero, less, equal, overflow}, a line with func ff ends the table
00 00000005 00000003 0 0 0000 00000008 00000000 0 // add
00 7fffffff 00000001 0 0 0000 80000000 00000000 1 // add overflow
01 12345678 12345678 0 0 0000 00000000 00000000 a // sub to zero
01 00000001 00000002 0 0 0000 ffffffff 00000000 4
01 80000000 00000001 0 0 0000 7fffffff 00000000 1 // sub overflow
05 f0f0f0f0 ff00ff00 0 0 0000 f000f000 00000000 4
06 f0f0f0f0 0f0f0f0f 0 0 0000 ffffffff 00000000 0
07 00000000 00000000 0 0 0000 ffffffff 00000000 2
07 ffff0000 0000ffff 0 0 0000 00000000 00000000 8
08 a5a5a5a5 a5a5a5a5 0 0 0000 00000000 00000000 a
08 12345678 ffffffff 0 0 0000 edcba987 00000000 4
00 00000100 deadbeef 1 1 fff0 000000f0 00000000 4 // imm sign extended
00 00000100 deadbeef 1 0 fff0 000100f0 00000000 4 // imm zero extended
06 12340000 deadbeef 1 0 5678 12345678 00000000 0
02 00000001 00000004 0 0 0000 00000010 00000000 4
02 00000003 00000021 0 0 0000 00000006 00000000 4 // amount 33 wraps to 1
04 80000000 0000001f 0 0 0000 00000001 00000000 0
03 80000000 00000004 0 0 0000 f8000000 00000000 0
03 fffffff0 00000024 0 0 0000 ffffffff 00000000 0 // amount 36 wraps to 4
04 fffffff0 00000024 0 0 0000 0fffffff 00000000 0
09 ffffffff 00000001 0 0 0000 00000001 00000000 4 // slts
0a ffffffff 00000001 0 0 0000 00000000 00000000 8 // sltu
09 00000001 ffffffff 0 0 0000 00000000 00000000 8
0b fffffffd 00000005 0 0 0000 fffffff1 ffffffff 0 // muls -3 x 5
0f 00000000 00000000 0 0 0000 fffffff1 ffffffff 2 // mflo
10 00000000 00000000 0 0 0000 ffffffff ffffffff 2 // mfhi
0c fffffffd 00000005 0 0 0000 fffffff1 00000004 0 // mulu
10 00000000 00000000 0 0 0000 00000004 00000004 2
0f 00000000 00000000 0 0 0000 fffffff1 00000004 2
0e 13572468 00000000 0 0 0000 13572468 13572468 0 // mthi
0d 2468ace0 00000000 0 0 0000 2468ace0 13572468 0 // mtlo
10 00000000 00000000 0 0 0000 13572468 13572468 2
0f 00000000 00000000 0 0 0000 2468ace0 13572468 2
1f cafef00d 00000000 0 0 0000 cafef00d 13572468 0 // unused code passes rs
0e 00000000 00000000 0 0 0000 00000000 00000000 a // clear HI
0d 00000000 00000000 0 0 0000 00000000 00000000 a // clear LO
ff 00000000 00000000 0 0 0000 00000000 00000000 0

// File: testbench/tb_mips_exec_unit.sv
`timescale 1ns/1ps
`include "mips_alu_params.svh"

module tb_mips_exec_unit;

	import mips_alu_pkg::*;

	localparam int MAX_VEC = 64;
	localparam int FIELDS  = 9;

	typedef struct packed {
		logic [31:0]        vec;
		logic [7:0]         tag;
		logic [`DATA_W-1:0] result;
		logic [`DATA_W-1:0] hi;
		logic [3:0]         flags; // {zero, less, equal, overflow}
		logic [31:0]        due;   // cycle count at which out_valid must be seen
	} expect_t;

	logic      clk;
	logic      arst_n;
	logic      in_valid;
	exec_req_t in_req;
	logic      out_valid;
	exec_out_t out;

	logic [31:0] stim_mem [0:MAX_VEC*FIELDS-1];
	expect_t     exp_q[$];
	logic [31:0] lfsr        = 32'hdb55;
	int unsigned cycle       = 0;
	int unsigned cycle_limit = 0;
	int unsigned num_vec     = 0;
	int unsigned checks      = 0;
	int unsigned errors      = 0;

	mips_exec_unit mips_exec_unit_i (
		.clk       (clk),
		.arst_n    (arst_n),
		.in_valid  (in_valid),
		.in_req    (in_req),
		.out_valid (out_valid),
		.out       (out)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	always @(posedge clk) begin
		cycle <= cycle + 1; // read only on falling edges, where it is stable
	end

	task automatic check_value(input string name, input logic [63:0] expected,
		input logic [63:0] actual);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("CHECK FAILED %s: expected %h, actual %h", name, expected, actual);
		end
	endtask

	// Fibonacci LFSR with taps 32, 22, 2 and 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] state);
		return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
	endfunction

	task automatic pick_gap(output int unsigned gap);
		logic [1:0] bits;
		int         b;
		for (b = 0; b < 2; b++) begin
			lfsr    = lfsr_next(lfsr);
			bits[b] = lfsr[0]; // one step per bit taken
		end
		gap = bits;
	endtask

	// drives one request for a falling-edge cycle and queues what should come back
	task automatic send_request(input int unsigned vec, input logic [7:0] tag);
		int unsigned base;
		expect_t     e;
		base              = vec * FIELDS;
		in_req.func       = alu_func_e'(stim_mem[base][4:0]);
		in_req.rs_val     = stim_mem[base+1];
		in_req.rt_val     = stim_mem[base+2];
		in_req.use_imm    = stim_mem[base+3][0];
		in_req.imm_signed = stim_mem[base+4][0];
		in_req.imm        = stim_mem[base+5][`IMM_W-1:0];
		in_req.tag        = tag;
		in_valid          = 1'b1;
		e.vec             = vec;
		e.tag             = tag;
		e.result          = stim_mem[base+6];
		e.hi              = stim_mem[base+7];
		e.flags           = stim_mem[base+8][3:0];
		e.due             = cycle + 2; // sampled at the next edge, out two edges later
		exp_q.push_back(e);
		@(negedge clk);
		in_valid = 1'b0;
	endtask

	always @(negedge clk) begin
		expect_t e;
		if (out_valid === 1'b1) begin
			if (exp_q.size() == 0) begin
				errors++;
				$display("out_valid pulsed at cycle %0d with no request outstanding", cycle);
			end else begin
				e = exp_q.pop_front();
				check_value($sformatf("vector %0d tag", e.vec), e.tag, out.tag);
				check_value($sformatf("vector %0d result", e.vec), e.result, out.result);
				check_value($sformatf("vector %0d hi", e.vec), e.hi, out.hi);
				check_value($sformatf("vector %0d flags", e.vec), e.flags, out.status);
				check_value($sformatf("vector %0d latency", e.vec), e.due, cycle);
			end
		end
	end

	initial begin
		int unsigned pass;
		int unsigned v;
		int unsigned gap;
		int unsigned waited;
		logic        found_end;
		arst_n   = 1'b0;
		in_valid = 1'b0;
		in_req   = '0;
		$readmemh("testbench/exec_stim.txt", stim_mem);
		found_end = 1'b0;
		v         = 0;
		while (v < MAX_VEC && !found_end) begin
			if (stim_mem[v*FIELDS] == 32'hff) begin
				found_end = 1'b1;
			end else begin
				v++;
			end
		end
		num_vec = v;
		if (!found_end) begin
			errors++;
			num_vec = 0;
			$display("stim file has no end marker line, no requests were sent");
		end
		cycle_limit = num_vec * 5 + 50;
		repeat (8) begin
			@(negedge clk);
			check_value("reset out_valid", 64'd0, out_valid);
		end
		arst_n = 1'b1;
		// the table leaves HI and LO at zero, so it can run twice, the second time back to back
		for (pass = 0; pass < 2; pass++) begin
			for (v = 0; v < num_vec; v++) begin
				send_request(v, 8'(pass * num_vec + v));
				if (pass == 0) begin
					pick_gap(gap);
					repeat (gap) @(negedge clk);
				end
			end
		end
		waited = 0;
		while (exp_q.size() != 0 && waited < 4) begin
			@(negedge clk);
			waited++;
		end
		if (exp_q.size() != 0) begin
			errors++;
			$display("%0d results never came out after the last request", exp_q.size());
		end
		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

	initial begin
		wait (cycle_limit != 0);
		while (cycle < cycle_limit) @(posedge clk);
		$display("timeout after %0d cycles, %0d results still outstanding", cycle, exp_q.size());
		$display("CHECKS FAILED");
		$finish;
	end

endmodule

// File: design/mips_exec_unit.sv
`timescale 1ns/1ps
`include "mips_alu_params.svh"

module mips_exec_unit (
	input  logic                     clk,
	input  logic                     arst_n,
	input  logic                     in_valid,
	input  mips_alu_pkg::exec_req_t  in_req,
	output logic                     out_valid,
	output mips_alu_pkg::exec_out_t  out
);

	import mips_alu_pkg::*;

	logic               op_valid;
	alu_operands_t      op;
	alu_result_t        alu_res;
	logic [`DATA_W-1:0] hi_q;
	logic [`DATA_W-1:0] lo_q;

	operand_stage operand_stage_i (
		.clk      (clk),
		.arst_n   (arst_n),
		.in_valid (in_valid),
		.in_req   (in_req),
		.op_valid (op_valid),
		.op       (op)
	);

	// HI and LO come back from the output stage for mfhi and mflo
	mips_alu mips_alu_i (
		.op     (op),
		.reg_hi (hi_q),
		.reg_lo (lo_q),
		.res    (alu_res)
	);

	hilo_result_stage hilo_result_stage_i (
		.clk       (clk),
		.arst_n    (arst_n),
		.res_valid (op_valid),
		.res       (alu_res),
		.hi_q      (hi_q),
		.lo_q      (lo_q),
		.out_valid (out_valid),
		.out       (out)
	);

endmodule

// File: design/hilo_result_stage.sv
`timescale 1ns/1ps
`include "mips_alu_params.svh"

module hilo_result_stage (
	input  logic                       clk,
	input  logic                       arst_n,
	input  logic                       res_valid,
	input  mips_alu_pkg::alu_result_t  res,
	output logic [`DATA_W-1:0]         hi_q,
	output logic [`DATA_W-1:0]         lo_q,
	output logic                       out_valid,
	output mips_alu_pkg::exec_out_t    out
);

	import mips_alu_pkg::*;

	logic               hi_wr;
	logic               lo_wr;
	logic [`DATA_W-1:0] hi_d;
	logic [`DATA_W-1:0] lo_d;
	exec_out_t          out_d;

	assign hi_wr = res_valid && res.hi_we;
	assign lo_wr = res_valid && res.lo_we;

	// next HI and LO, also what the output reports for HI
	assign hi_d = hi_wr ? res.res_hi : hi_q;
	assign lo_d = lo_wr ? res.res_lo : lo_q;

	always_comb begin
		out_d.result = res.res_lo;
		out_d.hi     = hi_d;
		out_d.status = res.status;
		out_d.tag    = res.tag;
	end

	// HI and LO update at the same edge that registers the result
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			hi_q <= '0;
			lo_q <= '0;
		end else begin
			hi_q <= hi_d;
			lo_q <= lo_d;
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			out_valid <= 1'b0;
		end else begin
			out_valid <= res_valid; // one pulse per result
		end
	end

	always_ff @(posedge clk) begin
		if (res_valid) begin
			out <= out_d;
		end
	end

endmodule

// File: design/mips_alu.sv
`timescale 1ns/1ps
`include "mips_alu_params.svh"

module mips_alu (
	input  mips_alu_pkg::alu_operands_t  op,
	input  logic [`DATA_W-1:0]           reg_hi,
	input  logic [`DATA_W-1:0]           reg_lo,
	output mips_alu_pkg::alu_result_t    res
);

	import mips_alu_pkg::*;

	logic signed [2*`DATA_W-1:0] mul_s;
	logic        [2*`DATA_W-1:0] mul_u;
	logic        [`DATA_W-1:0]   sum;
	logic        [`DATA_W-1:0]   diff;
	logic        [`DATA_W-1:0]   res_lo;
	logic        [`DATA_W-1:0]   res_hi;
	logic                        lt_s;
	logic                        lt_u;
	logic                        ovf_add;
	logic                        ovf_sub;

	assign mul_s = $signed(op.data1) * $signed(op.data2); // both operands widen with sign
	assign mul_u = op.data1 * op.data2;
	assign sum   = op.data1 + op.data2;
	assign diff  = op.data1 - op.data2;
	assign lt_s  = $signed(op.data1) < $signed(op.data2);
	assign lt_u  = op.data1 < op.data2;

	// overflow when the operand signs allow it and the result sign flips
	assign ovf_add = (op.data1[`DATA_W-1] == op.data2[`DATA_W-1]) &&
		(sum[`DATA_W-1] != op.data1[`DATA_W-1]);
	assign ovf_sub = (op.data1[`DATA_W-1] != op.data2[`DATA_W-1]) &&
		(diff[`DATA_W-1] != op.data1[`DATA_W-1]);

	always_comb begin
		case (op.func)
			ALU_ADD:  res_lo = sum;
			ALU_SUB:  res_lo = diff;
			ALU_SLL:  res_lo = op.data1 << op.shamt;
			ALU_SRA:  res_lo = $signed(op.data1) >>> op.shamt;
			ALU_SRL:  res_lo = op.data1 >> op.shamt;
			ALU_AND:  res_lo = op.data1 & op.data2;
			ALU_OR:   res_lo = op.data1 | op.data2;
			ALU_NOR:  res_lo = ~(op.data1 | op.data2);
			ALU_XOR:  res_lo = op.data1 ^ op.data2;
			ALU_SLTS: res_lo = `DATA_W'(lt_s);
			ALU_SLTU: res_lo = `DATA_W'(lt_u);
			ALU_MULS: res_lo = mul_s[`DATA_W-1:0];
			ALU_MULU: res_lo = mul_u[`DATA_W-1:0];
			ALU_MTLO: res_lo = op.data1;
			ALU_MTHI: res_lo = op.data1;
			ALU_MFLO: res_lo = reg_lo;
			ALU_MFHI: res_lo = reg_hi;
			default:  res_lo = op.data1;
		endcase
	end

	// only the multiplies and mthi carry anything to HI
	always_comb begin
		case (op.func)
			ALU_MULS: res_hi = mul_s[2*`DATA_W-1:`DATA_W];
			ALU_MULU: res_hi = mul_u[2*`DATA_W-1:`DATA_W];
			ALU_MTHI: res_hi = op.data1;
			default:  res_hi = '0;
		endcase
	end

	always_comb begin
		res.res_lo = res_lo;
		res.res_hi = res_hi;
		res.tag    = op.tag;

		res.hi_we = (op.func == ALU_MULS) || (op.func == ALU_MULU) || (op.func == ALU_MTHI);
		res.lo_we = (op.func == ALU_MULS) || (op.func == ALU_MULU) || (op.func == ALU_MTLO);

		res.status.zero  = ~(|res_lo);
		res.status.less  = (op.func == ALU_SLTS) ? lt_s : lt_u;
		res.status.equal = op.data1 == op.data2;

		case (op.func)
			ALU_ADD: res.status.overflow = ovf_add;
			ALU_SUB: res.status.overflow = ovf_sub;
			default: res.status.overflow = 1'b0; // reported as a flag, never trapped
		endcase
	end

endmodule

// File: design/operand_stage.sv
`timescale 1ns/1ps
`include "mips_alu_params.svh"

module operand_stage (
	input  logic                         clk,
	input  logic                         arst_n,
	input  logic                         in_valid,
	input  mips_alu_pkg::exec_req_t      in_req,
	output logic                         op_valid,
	output mips_alu_pkg::alu_operands_t  op
);

	import mips_alu_pkg::*;

	logic [`DATA_W-1:0] imm_ext;
	logic [`DATA_W-1:0] data2_sel;
	alu_operands_t      op_d;

	// the immediate is widened with its top bit or with zeros
	always_comb begin
		if (in_req.imm_signed) begin
			imm_ext = {{(`DATA_W-`IMM_W){in_req.imm[`IMM_W-1]}}, in_req.imm};
		end else begin
			imm_ext = {{(`DATA_W-`IMM_W){1'b0}}, in_req.imm};
		end
	end

	assign data2_sel = in_req.use_imm ? imm_ext : in_req.rt_val; // second operand mux

	always_comb begin
		op_d.func  = in_req.func;
		op_d.data1 = in_req.rs_val;
		op_d.data2 = data2_sel;
		op_d.shamt = data2_sel[`SHAMT_W-1:0]; // amounts above 31 wrap
		op_d.tag   = in_req.tag;
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			op_valid <= 1'b0;
		end else begin
			op_valid <= in_valid;
		end
	end

	// operand payload only moves on a strobe
	always_ff @(posedge clk) begin
		if (in_valid) begin
			op <= op_d;
		end
	end

endmodule

// File: design/mips_alu_pkg.sv
`include "mips_alu_params.svh"

package mips_alu_pkg;

	// ALU function codes, any code not listed passes data1 through
	typedef enum logic [4:0] {
		ALU_ADD  = 5'd0,
		ALU_SUB  = 5'd1,
		ALU_SLL  = 5'd2,
		ALU_SRA  = 5'd3,
		ALU_SRL  = 5'd4,
		ALU_AND  = 5'd5,
		ALU_OR   = 5'd6,
		ALU_NOR  = 5'd7,
		ALU_XOR  = 5'd8,
		ALU_SLTS = 5'd9,
		ALU_SLTU = 5'd10,
		ALU_MULS = 5'd11,
		ALU_MULU = 5'd12,
		ALU_MTLO = 5'd13,
		ALU_MTHI = 5'd14,
		ALU_MFLO = 5'd15,
		ALU_MFHI = 5'd16
	} alu_func_e;

	// request as it arrives at the execute stage
	typedef struct packed {
		alu_func_e           func;
		logic [`DATA_W-1:0]  rs_val;
		logic [`DATA_W-1:0]  rt_val;
		logic                use_imm;    // take the immediate instead of rt
		logic                imm_signed; // sign extend the immediate, else zero extend
		logic [`IMM_W-1:0]   imm;
		logic [7:0]          tag;        // travels with the request to the output
	} exec_req_t;

	// operands after the input register
	typedef struct packed {
		alu_func_e           func;
		logic [`DATA_W-1:0]  data1;
		logic [`DATA_W-1:0]  data2;
		logic [`SHAMT_W-1:0] shamt;
		logic [7:0]          tag;
	} alu_operands_t;

	typedef struct packed {
		logic zero;     // res_lo is all zeros
		logic less;     // signed compare only for slts
		logic equal;
		logic overflow; // signed overflow of add and sub
	} alu_status_t;

	// combinational ALU output
	typedef struct packed {
		logic [`DATA_W-1:0]  res_lo;
		logic [`DATA_W-1:0]  res_hi;
		logic                hi_we;
		logic                lo_we;
		alu_status_t         status;
		logic [7:0]          tag;
	} alu_result_t;

	// registered output of the execute stage
	typedef struct packed {
		logic [`DATA_W-1:0]  result;
		logic [`DATA_W-1:0]  hi;     // HI after this cycle's update
		alu_status_t         status;
		logic [7:0]          tag;
	} exec_out_t;

endpackage

// File: design/mips_alu_params.svh
`ifndef MIPS_ALU_PARAMS_SVH
`define MIPS_ALU_PARAMS_SVH

// datapath word width, HI/LO and the product split are tied to it
`define DATA_W 32

// shift amount is log2 of the word width
`define SHAMT_W 5

`define IMM_W 16

`endif
